// File: include/cpu_defs.svh
/*
 * Global widths, reset address and opcode byte values for the core.
 * Included by every RTL file that needs a width, the reset address or an
 * opcode constant. The testbench includes it as well.
 */

`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define DATA_W      8                   // Data bus and register width
`define ADDR_W      16                  // Address bus width
`define RESET_PC    16'h0200            // First fetch after reset

// Immediate ALU group
`define OPC_LDA_IMM 8'hA9
`define OPC_ORA_IMM 8'h09
`define OPC_AND_IMM 8'h29
`define OPC_EOR_IMM 8'h49
`define OPC_ADC_IMM 8'h69
`define OPC_SBC_IMM 8'hE9

`define OPC_LDX_IMM 8'hA2               // X register group
`define OPC_INX     8'hE8
`define OPC_DEX     8'hCA

`define OPC_LDA_ZP  8'hA5               // Zero page
`define OPC_STA_ZP  8'h85
`define OPC_STX_ZP  8'h86

`define OPC_CLC     8'h18               // Flags and flow
`define OPC_SEC     8'h38
`define OPC_JMP_ABS 8'h4C

`endif

// File: rtl/cpu_pkg.sv
/*
 * Shared types of the core: sequencer states, ALU operations, register
 * selector and the decode word latched at fetch. Modules pull these in
 * with a wildcard import in their header.
 */

`default_nettype none

package cpu_pkg;

    // Sequencer states, also used as the addressing mode of an opcode
    typedef enum logic [2:0] {
        RESET_S,                        // One cycle after reset
        FETCH,                          // Opcode read
        IMM,                            // Immediate operand read
        ZP,                             // Zero page address read
        ABS_LO,                         // Absolute address low byte
        ABS_HI,                         // Absolute address high byte
        DATA_RD,                        // Zero page data read
        DATA_WR                         // Zero page data write
    } cpu_state_e;

    typedef enum logic [2:0] {
        PASS,                           // Load operand
        OR,
        AND,
        XOR,
        ADC,                            // A + M + C
        SBC,                            // A + ~M + C
        INC,                            // X + 1
        DEC                             // X - 1
    } alu_op_e;

    typedef enum logic {
        REG_A,
        REG_X
    } reg_sel_e;

    // Control word produced once per instruction at fetch
    typedef struct packed {
        cpu_state_e mode;               // State after fetch
        alu_op_e    op;
        reg_sel_e   dst;                // Target of load, source of store
        logic       ld;                 // Write ALU result to dst
        logic       st;                 // Memory write instruction
        logic       jmp;                // Absolute address goes to PC
        logic       carry_set;          // Value for CLC/SEC
        logic       carry_wr;           // Carry gets updated
    } decode_t;

endpackage

`default_nettype wire

// File: rtl/mem_cmd_if.sv
/*
 * Single-access command channel from the sequencer to the bus port.
 * start pulses once per access; addr, we and wdata hold until done.
 * done pulses once with rdata valid in the same cycle.
 */

`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

interface mem_cmd_if;
    logic               start;          // One-cycle request pulse
    logic [`ADDR_W-1:0] addr;
    logic               we;             // 1 = write
    logic [`DATA_W-1:0] wdata;
    logic               done;           // Access finished
    logic [`DATA_W-1:0] rdata;          // Valid with done

    modport seq  (output start, addr, we, wdata, input done, rdata);
    modport port (input start, addr, we, wdata, output done, rdata);
endinterface

`default_nettype wire

// File: rtl/instr_decode.sv
/*
 * Opcode decoder. Purely combinational; the sequencer samples the result
 * in the cycle the opcode byte arrives and keeps it for the whole
 * instruction. Anything not listed decodes as a one-byte no-op.
 */

`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module instr_decode import cpu_pkg::*; (
    input  wire logic [`DATA_W-1:0] opcode,
    output decode_t                 dec
);

    always_comb begin
        dec           = '0;             // No load, no store, no jump
        dec.mode      = FETCH;          // Unknown opcode runs as a no-op
        dec.op        = PASS;
        dec.dst       = REG_A;
        casez (opcode)
            `OPC_LDA_IMM: begin
                dec.mode = IMM;
                dec.ld   = 1'b1;
            end
            `OPC_ORA_IMM: begin
                dec.mode = IMM;
                dec.op   = OR;
                dec.ld   = 1'b1;
            end
            `OPC_AND_IMM: begin
                dec.mode = IMM;
                dec.op   = AND;
                dec.ld   = 1'b1;
            end
            `OPC_EOR_IMM: begin
                dec.mode = IMM;
                dec.op   = XOR;
                dec.ld   = 1'b1;
            end
            `OPC_ADC_IMM: begin
                dec.mode     = IMM;
                dec.op       = ADC;
                dec.ld       = 1'b1;
                dec.carry_wr = 1'b1;    // Carry out of the adder
            end
            `OPC_SBC_IMM: begin
                dec.mode     = IMM;
                dec.op       = SBC;
                dec.ld       = 1'b1;
                dec.carry_wr = 1'b1;
            end
            `OPC_LDX_IMM: begin
                dec.mode = IMM;
                dec.dst  = REG_X;
                dec.ld   = 1'b1;
            end
            `OPC_INX: begin             // Single byte, no operand
                dec.op   = INC;
                dec.dst  = REG_X;
                dec.ld   = 1'b1;
            end
            `OPC_DEX: begin
                dec.op   = DEC;
                dec.dst  = REG_X;
                dec.ld   = 1'b1;
            end
            `OPC_LDA_ZP: begin
                dec.mode = ZP;
                dec.ld   = 1'b1;
            end
            `OPC_STA_ZP: begin
                dec.mode = ZP;
                dec.st   = 1'b1;
            end
            `OPC_STX_ZP: begin
                dec.mode = ZP;
                dec.dst  = REG_X;       // Store source
                dec.st   = 1'b1;
            end
            `OPC_CLC:     dec.carry_wr = 1'b1;
            `OPC_SEC: begin
                dec.carry_set = 1'b1;
                dec.carry_wr  = 1'b1;
            end
            `OPC_JMP_ABS: begin
                dec.mode = ABS_LO;
                dec.jmp  = 1'b1;
            end
            default: ;                  // Keep the no-op defaults
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/seq_ctl.sv
/*
 * Instruction sequencer. Fetches the opcode, latches its decode word and
 * walks the addressing-mode states, issuing one memory access per state
 * over the command channel. Pulses exec one cycle after the last access
 * of an instruction so the datapath can commit.
 */

`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module seq_ctl import cpu_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst,
    mem_cmd_if.seq                  cmd,
    input  wire logic [`DATA_W-1:0] store_data,    // A or X for stores
    output decode_t                 dec_q,
    output logic [`DATA_W-1:0]      operand,
    output logic                    exec
);

    cpu_state_e         state;
    logic [`ADDR_W-1:0] pc;
    logic               issued;         // Access of this state sent
    logic               last;           // Current access ends the instruction
    decode_t            dec;

    instr_decode instr_decode_i (
        .opcode (cmd.rdata),
        .dec    (dec)
    );

    // One request per state, held off until done clears issued
    assign cmd.start = (state != RESET_S) && !issued;
    assign cmd.we    = (state == DATA_WR);
    assign cmd.wdata = store_data;      // Stable for the whole instruction

    always_comb begin
        case (state)
            DATA_RD,
            DATA_WR: cmd.addr = {{(`ADDR_W-`DATA_W){1'b0}}, operand};  // Page zero
            default: cmd.addr = pc;     // Instruction stream
        endcase
    end

    always_comb begin
        case (state)
            FETCH:   last = (dec.mode == FETCH);   // Implied opcodes
            IMM,
            ABS_HI,
            DATA_RD,
            DATA_WR: last = 1'b1;
            default: last = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= RESET_S;
            pc     <= `RESET_PC;
            issued <= 1'b0;
            exec   <= 1'b0;
        end else begin
            exec <= cmd.done && last;
            if (cmd.start)
                issued <= 1'b1;
            if (state == RESET_S) begin
                state <= FETCH;
            end else if (cmd.done) begin
                issued <= 1'b0;
                case (state)
                    FETCH: begin
                        pc    <= pc + 1'b1;
                        state <= dec.mode;
                    end
                    IMM: begin
                        pc    <= pc + 1'b1;
                        state <= FETCH;
                    end
                    ZP: begin
                        pc    <= pc + 1'b1;
                        state <= dec_q.st ? DATA_WR : DATA_RD;
                    end
                    ABS_LO: begin
                        pc    <= pc + 1'b1;
                        state <= ABS_HI;
                    end
                    ABS_HI: begin
                        if (dec_q.jmp)
                            pc <= {cmd.rdata, operand};  // Jump target
                        else
                            pc <= pc + 1'b1;
                        state <= FETCH;
                    end
                    default: state <= FETCH;   // Data access done
                endcase
            end
        end
    end

    // Decode word and operand byte
    always_ff @(posedge clk) begin
        if (cmd.done) begin
            case (state)
                FETCH:   dec_q <= dec;
                IMM,
                ZP,
                ABS_LO,
                DATA_RD: operand <= cmd.rdata;   // Value or address low
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/mem_port.sv
/*
 * Bus port. Turns each command from the sequencer into one four-phase
 * req/ack cycle on the external bus. Address and write data are
 * registered at request time, read data is captured on ack. A start that
 * arrives before ack has dropped waits as pending.
 */

`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module mem_port (
    input  wire logic               clk,
    input  wire logic               rst,
    mem_cmd_if.port                 cmd,
    input  wire logic               mem_ack,
    input  wire logic [`DATA_W-1:0] mem_rdata,
    output logic                    mem_req,
    output logic                    mem_we,
    output logic [`ADDR_W-1:0]      mem_addr,
    output logic [`DATA_W-1:0]      mem_wdata
);

    typedef enum logic [1:0] {
        IDLE,                           // Bus free
        REQ,                            // req high, waiting for ack
        WAIT_LOW                        // req dropped, waiting for ack low
    } phase_e;

    phase_e             phase;
    logic               pending;        // Start seen during WAIT_LOW
    logic               launch;
    logic               done_q;
    logic [`DATA_W-1:0] rdata_q;

    assign launch    = (phase == IDLE) && (cmd.start || pending);
    assign cmd.done  = done_q;
    assign cmd.rdata = rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase   <= IDLE;
            pending <= 1'b0;
            mem_req <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (phase)
                IDLE: if (launch) begin
                    mem_req <= 1'b1;
                    pending <= 1'b0;
                    phase   <= REQ;
                end
                REQ: if (mem_ack) begin
                    mem_req <= 1'b0;    // Data latched this edge
                    done_q  <= 1'b1;
                    phase   <= WAIT_LOW;
                end
                WAIT_LOW: begin
                    if (cmd.start)
                        pending <= 1'b1;
                    if (!mem_ack)
                        phase <= IDLE;
                end
                default: phase <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            mem_addr  <= cmd.addr;
            mem_we    <= cmd.we;
            mem_wdata <= cmd.wdata;
        end
        if (phase == REQ && mem_ack)
            rdata_q <= mem_rdata;
    end

endmodule

`default_nettype wire

// File: rtl/datapath.sv
/*
 * Register file and ALU. Holds A, X and the carry flag and commits the
 * result of an instruction on exec. Also selects which register a store
 * instruction puts on the bus.
 */

`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module datapath import cpu_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               exec,
    input  wire decode_t            dec_q,
    input  wire logic [`DATA_W-1:0] operand,
    output logic [`DATA_W-1:0]      store_data
);

    logic [`DATA_W-1:0] a;
    logic [`DATA_W-1:0] x;
    logic               c;
    logic [`DATA_W-1:0] res;
    logic               c_out;

    always_comb begin
        res   = operand;
        c_out = c;
        case (dec_q.op)
            PASS: res = operand;
            OR:   res = a | operand;
            AND:  res = a & operand;
            XOR:  res = a ^ operand;
            ADC:  {c_out, res} = {1'b0, a} + {1'b0, operand}
                                 + {{`DATA_W{1'b0}}, c};
            SBC:  {c_out, res} = {1'b0, a} + {1'b0, ~operand}    // Borrow is ~C
                                 + {{`DATA_W{1'b0}}, c};
            INC:  res = x + 1'b1;       // Wraps FF to 00
            DEC:  res = x - 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            a <= '0;
            x <= '0;
            c <= 1'b0;
        end else if (exec) begin
            if (dec_q.ld) begin
                if (dec_q.dst == REG_X)
                    x <= res;
                else
                    a <= res;
            end
            if (dec_q.carry_wr)
                c <= (dec_q.op == ADC || dec_q.op == SBC) ? c_out : dec_q.carry_set;
        end
    end

    assign store_data = (dec_q.dst == REG_X) ? x : a;   // STX or STA

endmodule

`default_nettype wire

// File: rtl/cpu_top.sv
/*
 * Core top level. Connects the sequencer, the bus port and the datapath
 * and exposes the four-phase req/ack memory bus as plain ports.
 */

`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_top import cpu_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               mem_ack,
    input  wire logic [`DATA_W-1:0] mem_rdata,
    output logic                    mem_req,
    output logic                    mem_we,
    output logic [`ADDR_W-1:0]      mem_addr,
    output logic [`DATA_W-1:0]      mem_wdata
);

    decode_t            dec_q;          // Latched decode word
    logic [`DATA_W-1:0] operand;
    logic [`DATA_W-1:0] store_data;
    logic               exec;

    mem_cmd_if cmd_if ();               // Sequencer to bus port

    seq_ctl seq_ctl_i (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd_if.seq),
        .store_data (store_data),
        .dec_q      (dec_q),
        .operand    (operand),
        .exec       (exec)
    );

    mem_port mem_port_i (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd_if.port),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

    datapath datapath_i (
        .clk        (clk),
        .rst        (rst),
        .exec       (exec),
        .dec_q      (dec_q),
        .operand    (operand),
        .store_data (store_data)
    );

endmodule

`default_nettype wire

// File: bench/tb_cpu.sv
/*
 * Testbench for the core. Loads the program image and the expected write
 * list from bench/prog_stim.txt, answers every bus cycle from a 64 KiB
 * memory model with random ack delays, checks each write in order and
 * watches the four-phase req/ack handshake on every cycle. The run ends
 * once the program has settled in its closing self-loop.
 */

`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module tb_cpu;

    localparam int PERIOD    = 40;
    localparam int DRIVE_DLY = 2;       // Input drive after rising edge
    localparam int ACK_LIMIT = 64;      // Cycles allowed per handshake phase
    localparam int RUN_LIMIT = 6000;    // Cycles for the whole program

    logic               clk;
    logic               rst;
    logic               mem_ack;
    logic [`DATA_W-1:0] mem_rdata;
    logic               mem_req;
    logic               mem_we;
    logic [`ADDR_W-1:0] mem_addr;
    logic [`DATA_W-1:0] mem_wdata;

    logic [`DATA_W-1:0] mem [0:(1<<`ADDR_W)-1];
    logic [`ADDR_W-1:0] exp_addr_q [$];     // Expected writes, program order
    logic [`DATA_W-1:0] exp_data_q [$];
    logic [8*16-1:0]    exp_name_q [$];
    logic [31:0]        seed       = 32'd11673;
    int                 errors     = 0;
    int                 checks     = 0;
    int                 self_loops = 0;     // Opcode reads of the final JMP
    logic               timed_out  = 1'b0;
    logic               prev_req   = 1'b0;  // Bus state at the last sample
    logic               prev_ack   = 1'b0;
    logic               prev_we    = 1'b0;
    logic [`ADDR_W-1:0] prev_addr  = '0;
    logic [`DATA_W-1:0] prev_wdata = '0;

    cpu_top cpu_top_i (
        .clk       (clk),
        .rst       (rst),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    task automatic tick;                // Next drive point
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic random_wait;         // 0 to 3 cycles
        int n;
        seed = lcg_next(seed);
        n    = int'(seed[17:16]);
        repeat (n) tick();
    endtask

    // JMP absolute whose target is its own address
    function automatic logic is_self_jump(input logic [`ADDR_W-1:0] a);
        return mem[a] == `OPC_JMP_ABS && {mem[16'(a + 16'd2)], mem[16'(a + 16'd1)]} == a;
    endfunction

    task automatic load_stim;
        int               fd;
        int               n;
        logic [8*120-1:0] line;
        logic [31:0]      tag;
        logic [31:0]      a;
        logic [31:0]      b0;
        logic [31:0]      b1;
        logic [31:0]      b2;
        logic [8*16-1:0]  name;
        fd = $fopen("bench/prog_stim.txt", "r");
        checks++;
        assert (fd != 0) else begin
            errors++;
            $display("Could not open the stimulus file bench/prog_stim.txt");
        end
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                tag = '0;
                n   = $sscanf(line, "%s", tag);
                if (tag == "M") begin       // Up to three bytes from addr on
                    n = $sscanf(line, "%s %h %h %h %h", tag, a, b0, b1, b2);
                    if (n > 2)
                        mem[a[15:0]] = b0[7:0];
                    if (n > 3)
                        mem[16'(a + 32'd1)] = b1[7:0];
                    if (n > 4)
                        mem[16'(a + 32'd2)] = b2[7:0];
                end else if (tag == "W") begin
                    n = $sscanf(line, "%s %h %h %s", tag, a, b0, name);
                    exp_addr_q.push_back(a[15:0]);
                    exp_data_q.push_back(b0[7:0]);
                    exp_name_q.push_back(name);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_write(input logic [`ADDR_W-1:0] a, input logic [`DATA_W-1:0] d);
        checks++;
        assert (exp_addr_q.size() != 0) else begin
            errors++;
            $display("Unexpected write of %h to %h after the last expected write", d, a);
        end
        if (exp_addr_q.size() != 0) begin
            assert (a == exp_addr_q[0] && d == exp_data_q[0]) else begin
                errors++;
                $display("Fail %0s: expected %h at %h, actual %h at %h",
                         exp_name_q[0], exp_data_q[0], exp_addr_q[0], d, a);
            end
            void'(exp_addr_q.pop_front());
            void'(exp_data_q.pop_front());
            void'(exp_name_q.pop_front());
        end
    endtask

    task automatic wait_for_req(input logic level);
        int n;
        n = 0;
        while (mem_req !== level && n < ACK_LIMIT) begin
            tick();
            n++;
        end
        if (mem_req !== level) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout waiting for mem_req to go to %0d", level);
        end
    endtask

    task automatic serve_access;
        if (mem_we) begin
            mem[mem_addr] = mem_wdata;
            check_write(mem_addr, mem_wdata);
        end else begin
            mem_rdata = mem[mem_addr];
            if (is_self_jump(mem_addr))
                self_loops++;
        end
    endtask

    // Memory side of the four-phase handshake
    initial begin : memory_model
        while (!timed_out) begin
            wait_for_req(1'b1);
            if (!timed_out) begin
                random_wait();
                serve_access();
                mem_ack = 1'b1;
                wait_for_req(1'b0);
                random_wait();
                mem_ack = 1'b0;
            end
        end
    end

    // Handshake rules, sampled mid-cycle where the bus is settled
    always @(negedge clk) begin
        if (!rst) begin
            if (prev_req && !mem_req) begin
                checks++;
                assert (prev_ack) else begin
                    errors++;
                    $display("mem_req dropped before mem_ack was high at %0t", $time);
                end
            end
            if (!prev_req && mem_req) begin
                checks++;
                assert (!prev_ack) else begin
                    errors++;
                    $display("mem_req rose while mem_ack was still high at %0t", $time);
                end
            end
            if (prev_req && mem_req) begin
                checks++;
                assert (mem_addr == prev_addr && mem_we == prev_we
                        && mem_wdata == prev_wdata) else begin
                    errors++;
                    $display("Address, direction or write data moved during a request at %0t",
                             $time);
                end
            end
        end
        prev_req   = mem_req;
        prev_ack   = mem_ack;
        prev_addr  = mem_addr;
        prev_we    = mem_we;
        prev_wdata = mem_wdata;
    end

    initial begin : main
        int cycles;
        rst       = 1'b1;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        for (int i = 0; i < (1 << `ADDR_W); i++)
            mem[i] = 8'(i[15:8] ^ i[7:0] ^ 8'h5A);     // Background fill
        load_stim();
        repeat (2) tick();              // Two reset cycles
        rst    = 1'b0;
        cycles = 0;
        while (self_loops < 3 && !timed_out && cycles < RUN_LIMIT) begin
            tick();
            cycles++;
        end
        if (cycles >= RUN_LIMIT) begin
            errors++;
            $display("Timeout: the program never reached its self-loop");
        end
        checks++;
        assert (exp_addr_q.size() == 0) else begin
            errors++;
            $display("%0d expected writes never arrived", exp_addr_q.size());
        end
        $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/prog_stim.txt
// M addr b0 [b1 [b2]] : preload memory with one instruction's bytes from addr on
// W addr data name    : next expected bus write in program order
M 0200 A9 5A       // LDA #5A
M 0202 85 10       // STA 10
M 0204 09 81       // ORA #81
M 0206 29 F0       // AND #F0
M 0208 49 3C       // EOR #3C
M 020A 85 11       // STA 11
M 020C 38          // SEC
M 020D A9 F0       // LDA #F0
M 020F 69 20       // ADC #20 with carry in set
M 0211 85 12       // STA 12
M 0213 E9 05       // SBC #05 using carry out of ADC
M 0215 85 13       // STA 13
M 0217 18          // CLC
M 0218 E9 20       // SBC #20 with borrow
M 021A 85 14       // STA 14
M 021C 69 14       // ADC #14
M 021E 85 15       // STA 15
M 0220 A2 FE       // LDX #FE
M 0222 E8          // INX
M 0223 E8          // INX wraps to 00
M 0224 86 16       // STX 16
M 0226 CA          // DEX wraps to FF
M 0227 86 17       // STX 17
M 0229 A5 11       // LDA 11
M 022B 85 18       // STA 18
M 022D 4C 34 02    // JMP 0234
M 0230 A9 E7       // Poison load never reached
M 0232 85 19       // Poison store never reached
M 0234 EA          // Unknown opcode as no-op
M 0235 4C 35 02    // JMP 0235 self-loop
W 0010 5A lda_imm_sta
W 0011 EC alu_logic
W 0012 11 adc_sec
W 0013 0C sbc_carry_in
W 0014 EB sbc_borrow
W 0015 FF adc_clear
W 0016 00 inx_wrap
W 0017 FF dex_wrap
W 0018 EC lda_zp

// File: sim.f
+incdir+include
rtl/cpu_pkg.sv
rtl/mem_cmd_if.sv
rtl/instr_decode.sv
rtl/seq_ctl.sv
rtl/mem_port.sv
rtl/datapath.sv
rtl/cpu_top.sv
bench/tb_cpu.sv

// File: Makefile
# Verilator build and run of the core testbench
TOP = tb_cpu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module $(TOP) -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
